// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --assert -j 0
TOP      := ooo_core_tb
FILELIST := vlog.f

OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/ooo_core_properties.sv ====
`default_nettype none

module ooo_core_properties import ooo_pkg::*; #(
  parameter int rob_depth = 8
) (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           commit_valid,
  input logic [$clog2(rob_depth+1)-1:0] count,
  input logic                           cdb_valid,
  input tag_t                           cdb_tag,
  input logic                           cdb_is_mul,
  input logic                           issue_valid,
  input tag_t                           issue_tag,
  input logic                           ent_valid [rob_depth],
  input logic                           ent_done  [rob_depth]
);

  localparam int idx_w = (rob_depth > 1) ? $clog2(rob_depth) : 1;

  int               violation_count = 0;
  logic [idx_w-1:0] bus_idx;

  assign bus_idx = cdb_tag[idx_w-1:0];

  ////////////////////////////////////////
  // reorder buffer.
  ////////////////////////////////////////

  quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !commit_valid)
    else begin
      $error("commit_valid high in the cycle after reset");
      violation_count = violation_count + 1;
    end

  occupancy_bound: assert property (@(posedge clk) disable iff (!rst_n)
      count <= rob_depth)
    else begin
      $error("reorder buffer holds more than rob_depth entries");
      violation_count = violation_count + 1;
    end

  // a broadcast must finish a live entry.
  bus_tag_live: assert property (@(posedge clk) disable iff (!rst_n)
      cdb_valid |-> ent_valid[bus_idx] && !ent_done[bus_idx])
    else begin
      $error("bus tag names a free or finished entry");
      violation_count = violation_count + 1;
    end

  // a multiply result needs three cycles after its entry is taken.
  mul_latency: assert property (@(posedge clk) disable iff (!rst_n)
      cdb_valid && cdb_is_mul |->
        !($past(issue_valid) && $past(issue_tag) == cdb_tag) &&
        !($past(issue_valid, 2) && $past(issue_tag, 2) == cdb_tag))
    else begin
      $error("multiply result arrived too early for its entry");
      violation_count = violation_count + 1;
    end

endmodule

`default_nettype wire

// ==== dv/ooo_core_tb.sv ====
`default_nettype none

module ooo_core_tb import ooo_pkg::*; ();

  localparam int rob_depth     = 8;
  localparam int station_depth = 4;
  localparam int max_entries   = 64;
  localparam int wait_limit    = 200;
  localparam int quiet_cycles  = 20;

  logic              clk;
  logic              rst_n;
  logic              instr_valid;
  logic [data_w-1:0] instr;
  logic              instr_ready;
  logic              commit_valid;
  reg_idx_t          commit_reg;
  logic [data_w-1:0] commit_data;

  // word, burst flag, expected reg and expected value per line.
  logic [71:0]       stim_raw  [max_entries];
  logic [data_w-1:0] instr_mem [max_entries];
  logic              burst_mem [max_entries];
  logic [35:0]       exp_pair  [max_entries];

  int                entry_count;
  logic              saw_stall;
  logic [31:0]       lfsr_state;

  ooo_core #(
    .rob_depth     (rob_depth),
    .station_depth (station_depth)
  ) u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .instr_ready  (instr_ready),
    .commit_valid (commit_valid),
    .commit_reg   (commit_reg),
    .commit_data  (commit_data)
  );

  bind reorder_buffer ooo_core_properties #(.rob_depth(rob_depth)) rob_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .commit_valid (commit_valid),
    .count        (count),
    .cdb_valid    (cdb.valid),
    .cdb_tag      (cdb.tag),
    .cdb_is_mul   (cdb.is_mul),
    .issue_valid  (issue.valid),
    .issue_tag    (issue.tag),
    .ent_valid    (ent_valid),
    .ent_done     (ent_done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers.
  ////////////////////////////////////////

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic pick_gap(output int gap);
    gap = 0;
    repeat (2) begin
      lfsr_state = lfsr_step(lfsr_state);
      gap = (gap << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic stop_failed();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [data_w-1:0] expected,
                             input logic [data_w-1:0] actual);
    if (actual !== expected) begin
      $display("Error at time %0t: %s expected 0x%08h, actual 0x%08h",
               $time, name, expected, actual);
      stop_failed();
    end
  endtask

  task automatic load_stimulus();
    $readmemh("dv/ooo_stimulus.txt", stim_raw);
    entry_count = 0;
    while (entry_count < max_entries && stim_raw[entry_count][39:36] != 4'hf) begin
      instr_mem[entry_count] = stim_raw[entry_count][71:40];
      burst_mem[entry_count] = stim_raw[entry_count][36];
      exp_pair[entry_count]  = stim_raw[entry_count][35:0];
      entry_count++;
    end
    if (entry_count == 0 || entry_count == max_entries) begin
      $display("stimulus file is empty or lacks its end marker");
      stop_failed();
    end
  endtask

  ////////////////////////////////////////
  // driver.
  ////////////////////////////////////////

  initial begin : drive_stimulus
    int gap;
    int waited;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    saw_stall   = 1'b0;
    lfsr_state  = 32'h3a77_fbec;
    load_stimulus();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < entry_count; i++) begin
      if (!burst_mem[i]) begin
        pick_gap(gap);
        repeat (gap) @(negedge clk);
      end
      instr_valid = 1'b1;
      instr       = instr_mem[i];
      waited      = 0;
      // word held until the core takes it.
      while (!instr_ready) begin
        if (burst_mem[i]) begin
          saw_stall = 1'b1;
        end
        waited++;
        if (waited > wait_limit) begin
          $display("timeout: instruction %0d was never accepted", i);
          stop_failed();
        end
        @(negedge clk);
      end
      @(negedge clk);
      instr_valid = 1'b0;
    end
  end

  ////////////////////////////////////////
  // commit monitor.
  ////////////////////////////////////////

  initial begin : check_commits
    int idle;
    idle = 0;
    while (rst_n !== 1'b1) begin
      idle++;
      if (idle > wait_limit) begin
        $display("timeout: reset was never released");
        stop_failed();
      end
      @(negedge clk);
    end
    for (int n = 0; n < entry_count; n++) begin
      idle = 0;
      @(negedge clk);
      while (commit_valid !== 1'b1) begin
        idle++;
        if (idle > wait_limit) begin
          $display("timeout: commit %0d of %0d never arrived", n, entry_count);
          stop_failed();
        end
        @(negedge clk);
      end
      check_value("commit_reg", data_w'(exp_pair[n][35:32]), data_w'(commit_reg));
      check_value("commit_data", exp_pair[n][31:0], commit_data);
    end
    // no extra commits after the program drains.
    repeat (quiet_cycles) begin
      @(negedge clk);
      check_value("commit_valid", 32'd0, data_w'(commit_valid));
    end
    check_value("saw_stall", 32'd1, data_w'(saw_stall));
    check_value("violation_count", 32'd0, data_w'(u_dut.rob.rob_props.violation_count));
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/ooo_stimulus.txt ====
// columns: instruction word, burst flag (1 = no idle before it), commit reg, commit value
// program order; a line with burst flag f ends the program
09000005_0_1_00000005
0a00fffd_0_2_fffffffd
3b001234_0_3_00001234
04280000_0_4_00000002
45640000_0_5_00001231
16700000_0_6_00001232
27740000_0_7_00001230
59200004_0_1_00000050
01300000_0_1_00000052
6a200001_0_2_00000029
12440000_0_2_ffffffd7
73380000_0_3_0005d404
0c000007_0_4_00000007
0d000009_0_5_00000009
0e000011_0_6_00000011
0e000022_0_6_00000022
07d00000_0_7_00000029
716c0000_1_1_f7bea010
72940000_1_2_0000003f
73fc0000_1_3_00000691
04280000_1_4_f7bea04f
054c0000_1_5_000006d0
4e6000ff_1_6_0000066e
17b00000_1_7_08416681
70d40000_1_0_002bcd60
0900ffff_1_1_002bcd5f
00000000_f_0_00000000

// ==== verilog/alu_station.sv ====
`default_nettype none

module alu_station import ooo_pkg::*; #(
  parameter int station_depth = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  instr_issue_if.receiver     issue,
  common_data_bus_if.driver   cdb,
  output logic                station_full
);

  localparam int sel_w = (station_depth > 1) ? $clog2(station_depth) : 1;
  localparam int cnt_w = $clog2(station_depth + 1);

  logic     ent_valid [station_depth];
  alu_op_t  ent_op    [station_depth];
  tag_t     ent_tag   [station_depth];
  operand_t ent_a     [station_depth];
  operand_t ent_b     [station_depth];

  logic [cnt_w-1:0]  used;
  logic [sel_w-1:0]  sel_idx;
  logic [sel_w-1:0]  free_idx;
  logic              sel_found;
  logic              mul_sel;
  logic              alu_fire;
  logic [data_w-1:0] alu_result;

  // multiply pipe holds operands, then the product.
  logic              m1_valid;
  logic [data_w-1:0] m1_a;
  logic [data_w-1:0] m1_b;
  tag_t              m1_tag;
  logic              m2_valid;
  logic [data_w-1:0] m2_data;
  tag_t              m2_tag;

  function automatic logic [data_w-1:0] alu_calc(alu_op_t op, logic [data_w-1:0] a,
                                                 logic [data_w-1:0] b);
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_sll:  return a << b[4:0];
      op_srl:  return a >> b[4:0];
      default: return '0;
    endcase
  endfunction

  ////////////////////////////////////////
  // select and occupancy.
  ////////////////////////////////////////

  // walk downward so the lowest index wins.
  always_comb begin
    used      = '0;
    sel_found = 1'b0;
    sel_idx   = '0;
    free_idx  = '0;
    for (int i = station_depth - 1; i >= 0; i--) begin
      if (ent_valid[i]) begin
        used = used + 1'b1;
      end else begin
        free_idx = sel_w'(i);
      end
      // alu ops hold off while the multiply result owns the bus.
      if (ent_valid[i] && ent_a[i].ready && ent_b[i].ready &&
          (ent_op[i] == op_mul || !m2_valid)) begin
        sel_found = 1'b1;
        sel_idx   = sel_w'(i);
      end
    end
  end

  // the word still in the issue register needs a slot too.
  assign station_full = (int'(used) + int'(issue.valid)) >= station_depth;

  assign mul_sel    = sel_found && ent_op[sel_idx] == op_mul;
  assign alu_fire   = sel_found && !mul_sel;
  assign alu_result = alu_calc(ent_op[sel_idx], ent_a[sel_idx].value, ent_b[sel_idx].value);

  assign cdb.valid  = m2_valid || alu_fire;
  assign cdb.is_mul = m2_valid;
  assign cdb.tag    = m2_valid ? m2_tag : ent_tag[sel_idx];
  assign cdb.data   = m2_valid ? m2_data : alu_result;

  ////////////////////////////////////////
  // state.
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < station_depth; i++) begin
        ent_valid[i] <= 1'b0;
      end
      m1_valid <= 1'b0;
      m2_valid <= 1'b0;
    end else begin
      if (sel_found) begin
        ent_valid[sel_idx] <= 1'b0;
      end
      if (issue.valid) begin
        ent_valid[free_idx] <= 1'b1;
      end
      m1_valid <= mul_sel;
      m2_valid <= m1_valid;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < station_depth; i++) begin
      ent_a[i] <= snoop(ent_a[i], cdb.valid, cdb.tag, cdb.data);
      ent_b[i] <= snoop(ent_b[i], cdb.valid, cdb.tag, cdb.data);
    end
    if (issue.valid) begin
      ent_op[free_idx]  <= issue.op;
      ent_tag[free_idx] <= issue.tag;
      ent_a[free_idx]   <= snoop(issue.op1, cdb.valid, cdb.tag, cdb.data);
      ent_b[free_idx]   <= snoop(issue.op2, cdb.valid, cdb.tag, cdb.data);
    end
    m1_a    <= ent_a[sel_idx].value;
    m1_b    <= ent_b[sel_idx].value;
    m1_tag  <= ent_tag[sel_idx];
    m2_data <= m1_a * m1_b;
    m2_tag  <= m1_tag;
  end

endmodule

`default_nettype wire

// ==== verilog/common_data_bus_if.sv ====
`default_nettype none

interface common_data_bus_if import ooo_pkg::*; ();

  logic              valid;
  tag_t              tag;
  logic [data_w-1:0] data;
  // high when the multiply pipe owns the bus.
  logic              is_mul;

  modport driver (
    output valid, tag, data, is_mul
  );

  modport listener (
    input valid, tag, data, is_mul
  );

endinterface

`default_nettype wire

// ==== verilog/dispatch.sv ====
`default_nettype none

module dispatch import ooo_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                instr_valid,
  input  instr_word_u         instr,
  output logic                instr_ready,
  input  logic                station_full,
  input  logic                rob_full,
  input  tag_t                next_tag,
  output reg_idx_t            query_rs1,
  output reg_idx_t            query_rs2,
  input  operand_t            query_op1,
  input  operand_t            query_op2,
  output logic                rename_valid,
  output reg_idx_t            rename_reg,
  output tag_t                rename_tag,
  common_data_bus_if.listener cdb,
  instr_issue_if.driver       issue
);

  logic     accept;
  alu_op_t  dec_op;
  reg_idx_t dec_rd;
  operand_t dec_op1;
  operand_t dec_op2;

  ////////////////////////////////////////
  // decode.
  ////////////////////////////////////////

  always_comb begin
    dec_op    = instr.rr.op;
    dec_rd    = instr.rr.rd;
    query_rs1 = instr.rr.rs1;
    query_rs2 = '0;
    dec_op1   = query_op1;
    if (instr.ri.fmt) begin
      dec_op2.value = {{(data_w-16){instr.ri.imm[15]}}, instr.ri.imm};
      dec_op2.ready = 1'b1;
      dec_op2.tag   = '0;
    end else begin
      query_rs2 = instr.rr.rs2;
      dec_op2   = query_op2;
    end
  end

  assign instr_ready = !station_full && !rob_full;
  assign accept      = instr_valid && instr_ready;

  // dest is renamed on the accept edge so the next word sees the new tag.
  assign rename_valid = accept;
  assign rename_reg   = dec_rd;
  assign rename_tag   = next_tag;

  ////////////////////////////////////////
  // issue register.
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      issue.op   <= dec_op;
      issue.tag  <= next_tag;
      issue.dest <= dec_rd;
      // a result on the bus right now would never be seen again.
      issue.op1  <= snoop(dec_op1, cdb.valid, cdb.tag, cdb.data);
      issue.op2  <= snoop(dec_op2, cdb.valid, cdb.tag, cdb.data);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/instr_issue_if.sv ====
`default_nettype none

interface instr_issue_if import ooo_pkg::*; ();

  logic     valid;
  alu_op_t  op;
  tag_t     tag;
  reg_idx_t dest;
  operand_t op1;
  operand_t op2;

  modport driver (
    output valid, op, tag, dest, op1, op2
  );

  modport receiver (
    input valid, op, tag, dest, op1, op2
  );

  // rob only needs to know that an entry was taken.
  modport listener (
    input valid, tag, dest
  );

endinterface

`default_nettype wire

// ==== verilog/ooo_core.sv ====
`default_nettype none

module ooo_core import ooo_pkg::*; #(
  parameter int rob_depth = 8,
  parameter int station_depth = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  logic [data_w-1:0] instr,
  output logic              instr_ready,
  output logic              commit_valid,
  output reg_idx_t          commit_reg,
  output logic [data_w-1:0] commit_data
);

  common_data_bus_if cdb ();
  instr_issue_if     issue ();

  logic     station_full;
  logic     rob_full;
  tag_t     next_tag;
  reg_idx_t query_rs1;
  reg_idx_t query_rs2;
  operand_t query_op1;
  operand_t query_op2;
  logic     rename_valid;
  reg_idx_t rename_reg;
  tag_t     rename_tag;
  tag_t     commit_tag;

  ////////////////////////////////////////
  // front end.
  ////////////////////////////////////////

  dispatch disp (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .instr_ready  (instr_ready),
    .station_full (station_full),
    .rob_full     (rob_full),
    .next_tag     (next_tag),
    .query_rs1    (query_rs1),
    .query_rs2    (query_rs2),
    .query_op1    (query_op1),
    .query_op2    (query_op2),
    .rename_valid (rename_valid),
    .rename_reg   (rename_reg),
    .rename_tag   (rename_tag),
    .cdb          (cdb),
    .issue        (issue)
  );

  register_file regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .query_rs1    (query_rs1),
    .query_rs2    (query_rs2),
    .query_op1    (query_op1),
    .query_op2    (query_op2),
    .rename_valid (rename_valid),
    .rename_reg   (rename_reg),
    .rename_tag   (rename_tag),
    .commit_valid (commit_valid),
    .commit_reg   (commit_reg),
    .commit_data  (commit_data),
    .commit_tag   (commit_tag)
  );

  ////////////////////////////////////////
  // execute and retire.
  ////////////////////////////////////////

  alu_station #(station_depth) alu_rs (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue        (issue),
    .cdb          (cdb),
    .station_full (station_full)
  );

  reorder_buffer #(rob_depth) rob (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue        (issue),
    .cdb          (cdb),
    .rob_full     (rob_full),
    .next_tag     (next_tag),
    .commit_valid (commit_valid),
    .commit_reg   (commit_reg),
    .commit_data  (commit_data),
    .commit_tag   (commit_tag)
  );

endmodule

`default_nettype wire

// ==== verilog/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

  localparam int data_w = 32;
  localparam int reg_count = 8;

  typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

  // wide enough for rob_depth up to 64; modules use the low bits.
  typedef logic [5:0] tag_t;

  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_and = 4'd2,
    op_or  = 4'd3,
    op_xor = 4'd4,
    op_sll = 4'd5,
    op_srl = 4'd6,
    op_mul = 4'd7
  } alu_op_t;

  typedef struct packed {
    alu_op_t     op;
    logic        fmt;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [17:0] spare;
  } instr_rr_t;

  typedef struct packed {
    alu_op_t            op;
    logic               fmt;
    reg_idx_t           rd;
    reg_idx_t           rs1;
    logic [4:0]         spare;
    logic signed [15:0] imm;
  } instr_ri_t;

  typedef union packed {
    instr_rr_t rr;
    instr_ri_t ri;
  } instr_word_u;

  typedef struct packed {
    logic [data_w-1:0] value;
    logic              ready;
    tag_t              tag;
  } operand_t;

  // pick up a broadcast for an operand still waiting on its tag.
  function automatic operand_t snoop(operand_t opnd, logic bus_valid, tag_t bus_tag,
                                     logic [data_w-1:0] bus_data);
    operand_t res;
    res = opnd;
    if (!opnd.ready && bus_valid && bus_tag == opnd.tag) begin
      res.value = bus_data;
      res.ready = 1'b1;
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/register_file.sv ====
`default_nettype none

module register_file import ooo_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  reg_idx_t          query_rs1,
  input  reg_idx_t          query_rs2,
  output operand_t          query_op1,
  output operand_t          query_op2,
  input  logic              rename_valid,
  input  reg_idx_t          rename_reg,
  input  tag_t              rename_tag,
  input  logic              commit_valid,
  input  reg_idx_t          commit_reg,
  input  logic [data_w-1:0] commit_data,
  input  tag_t              commit_tag
);

  logic [data_w-1:0] reg_value [reg_count];
  logic              reg_pend  [reg_count];
  tag_t              reg_tag   [reg_count];

  // same-cycle commit of the awaited tag counts as ready.
  function automatic operand_t lookup(reg_idx_t r);
    operand_t o;
    o.value = reg_value[r];
    o.ready = !reg_pend[r];
    o.tag   = reg_tag[r];
    if (commit_valid && commit_reg == r && commit_tag == reg_tag[r]) begin
      o.value = commit_data;
      o.ready = 1'b1;
    end
    return o;
  endfunction

  always_comb begin
    query_op1 = lookup(query_rs1);
    query_op2 = lookup(query_rs2);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        reg_value[i] <= '0;
        reg_pend[i]  <= 1'b0;
        reg_tag[i]   <= '0;
      end
    end else begin
      if (commit_valid) begin
        reg_value[commit_reg] <= commit_data;
        // a younger rename keeps the register pending.
        if (reg_tag[commit_reg] == commit_tag) begin
          reg_pend[commit_reg] <= 1'b0;
        end
      end
      if (rename_valid) begin
        reg_pend[rename_reg] <= 1'b1;
        reg_tag[rename_reg]  <= rename_tag;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/reorder_buffer.sv ====
`default_nettype none

module reorder_buffer import ooo_pkg::*; #(
  parameter int rob_depth = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  instr_issue_if.listener     issue,
  common_data_bus_if.listener cdb,
  output logic                rob_full,
  output tag_t                next_tag,
  output logic                commit_valid,
  output reg_idx_t            commit_reg,
  output logic [data_w-1:0]   commit_data,
  output tag_t                commit_tag
);

  localparam int idx_w = (rob_depth > 1) ? $clog2(rob_depth) : 1;
  localparam int cnt_w = $clog2(rob_depth + 1);

  typedef logic [idx_w-1:0] idx_t;

  logic              ent_valid [rob_depth];
  logic              ent_done  [rob_depth];
  reg_idx_t          ent_reg   [rob_depth];
  logic [data_w-1:0] ent_data  [rob_depth];

  idx_t             head;
  idx_t             tail;
  logic [cnt_w-1:0] count;
  logic             done_waiting;

  function automatic idx_t step(idx_t p);
    return (p == idx_t'(rob_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign commit_valid = ent_valid[head] && ent_done[head];
  assign commit_reg   = ent_reg[head];
  assign commit_data  = ent_data[head];
  assign commit_tag   = tag_t'(head);

  // the issue register holds a word whose entry is not taken yet.
  assign next_tag = tag_t'(issue.valid ? step(tail) : tail);

  // finished results behind the head are invisible to the register file,
  // so a new reader could miss them.
  always_comb begin
    done_waiting = 1'b0;
    for (int i = 0; i < rob_depth; i++) begin
      if (ent_valid[i] && ent_done[i] && idx_t'(i) != head) begin
        done_waiting = 1'b1;
      end
    end
  end

  assign rob_full = (int'(count) + int'(issue.valid)) >= rob_depth || done_waiting;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < rob_depth; i++) begin
        ent_valid[i] <= 1'b0;
        ent_done[i]  <= 1'b0;
      end
    end else begin
      if (issue.valid) begin
        ent_valid[tail] <= 1'b1;
        ent_done[tail]  <= 1'b0;
        tail            <= step(tail);
      end
      if (cdb.valid) begin
        ent_done[cdb.tag[idx_w-1:0]] <= 1'b1;
      end
      if (commit_valid) begin
        ent_valid[head] <= 1'b0;
        head            <= step(head);
      end
      count <= count + cnt_w'(issue.valid) - cnt_w'(commit_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (issue.valid) begin
      ent_reg[tail] <= issue.dest;
    end
    if (cdb.valid) begin
      ent_data[cdb.tag[idx_w-1:0]] <= cdb.data;
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/ooo_pkg.sv
verilog/common_data_bus_if.sv
verilog/instr_issue_if.sv
verilog/dispatch.sv
verilog/register_file.sv
verilog/alu_station.sv
verilog/reorder_buffer.sv
verilog/ooo_core.sv
dv/ooo_core_properties.sv
dv/ooo_core_tb.sv
